// ==== src/mul_pkg.sv ====
`default_nettype none

package mul_pkg;

	// Datapath widths.
	localparam int XLEN = 32;           // Register width.
	localparam int PROD_W = 2 * XLEN;   // Full product width.

	// Iterative core sizing.
	localparam int STEP_SIZE = 8;                          // Factor bits per core cycle.
	localparam int CORE_STEPS = XLEN / STEP_SIZE;          // Accumulation cycles per operation.
	localparam int STEP_CNT_W = $clog2(CORE_STEPS);        // Step counter width.

	// Core FSM states.
	localparam logic CORE_IDLE = 1'b0;  // Waiting for start, loading factors.
	localparam logic CORE_OP = 1'b1;    // Accumulating slices.

	// Operation encoding.
	localparam int OP_W = 2;
	localparam logic [OP_W-1:0] OP_MUL = 2'd0;     // Low word, sign agnostic.
	localparam logic [OP_W-1:0] OP_MULH = 2'd1;    // High word, signed x signed.
	localparam logic [OP_W-1:0] OP_MULHSU = 2'd2;  // High word, signed x unsigned.
	localparam logic [OP_W-1:0] OP_MULHU = 2'd3;   // High word, unsigned x unsigned.

endpackage

`default_nettype wire

// ==== src/mul_operand_conditioner.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_operand_conditioner (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       valid,
	input  wire [mul_pkg::OP_W-1:0]   op,
	input  wire [mul_pkg::XLEN-1:0]   rs1,
	input  wire [mul_pkg::XLEN-1:0]   rs2,
	input  wire                       core_busy,
	output logic                      busy,
	output logic                      start,
	output logic [mul_pkg::XLEN-1:0]  factor_a,
	output logic [mul_pkg::XLEN-1:0]  factor_b,
	output logic                      neg_product,
	output logic                      take_high
);

	import mul_pkg::*;

	logic accept;      // Request taken this cycle.
	logic rs1_signed;  // rs1 read as two's complement.
	logic rs2_signed;  // rs2 read as two's complement.
	logic neg_a;       // rs1 is a negative signed operand.
	logic neg_b;       // rs2 is a negative signed operand.
	logic held;        // Operation in flight, up to the done cycle.

	// Unit stays busy from acceptance until the result stage fires.
	assign busy = start | core_busy | held;
	assign accept = valid & ~busy;  // Requests while busy are dropped.

	// Signedness per opcode.
	assign rs1_signed = (op == OP_MULH) || (op == OP_MULHSU);  // MULH and MULHSU.
	assign rs2_signed = (op == OP_MULH);                       // MULH only.

	assign neg_a = rs1_signed & rs1[XLEN-1];  // Sign bit counts only when signed.
	assign neg_b = rs2_signed & rs2[XLEN-1];

	// Control flags.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			start <= 1'b0;
			held <= 1'b0;
		end else begin
			start <= accept;  // One-cycle pulse to the core.
			if (accept) begin
				held <= 1'b1;
			end else if (!start && !core_busy) begin
				held <= 1'b0;  // Core went idle last cycle, result lands now.
			end
		end
	end

	// Operand magnitudes and result flags.
	always_ff @(posedge clk) begin
		if (accept) begin
			factor_a <= neg_a ? (~rs1 + 1'b1) : rs1;  // Two's-complement magnitude.
			factor_b <= neg_b ? (~rs2 + 1'b1) : rs2;
			neg_product <= neg_a ^ neg_b;           // Signs differ, product is negative.
			take_high <= (op != OP_MUL);            // Every MULH* returns bits 63:32.
		end
	end

endmodule

`default_nettype wire

// ==== src/mul_unsigned_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_unsigned_core (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire                         start,
	input  wire [mul_pkg::XLEN-1:0]     factor_a,
	input  wire [mul_pkg::XLEN-1:0]     factor_b,
	output logic                        core_busy,
	output logic                        core_ready,
	output logic [mul_pkg::PROD_W-1:0]  product
);

	import mul_pkg::*;

	logic                   state;       // CORE_IDLE or CORE_OP.
	logic [STEP_CNT_W-1:0]  step_cnt;    // Slices consumed so far.
	logic [XLEN-1:0]        r_factor;    // Shifts right one slice per step.
	logic [PROD_W-1:0]      r_addvalue;  // Shifts left one slice per step.
	logic [PROD_W-1:0]      partial;     // Current slice times addend.
	logic                   last_step;   // Final slice this cycle.

	assign core_busy = (state == CORE_OP);  // Busy for the whole accumulation.

	// Low slice of the multiplier times the aligned multiplicand.
	assign partial = PROD_W'(r_factor[STEP_SIZE-1:0]) * r_addvalue;

	assign last_step = (step_cnt == STEP_CNT_W'(CORE_STEPS - 1));

	// FSM and step counter.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= CORE_IDLE;
			step_cnt <= '0;
			core_ready <= 1'b0;
		end else begin
			core_ready <= 1'b0;  // Pulse by default low.
			case (state)
				CORE_IDLE: begin
					step_cnt <= '0;
					if (start) begin
						state <= CORE_OP;
					end
				end
				CORE_OP: begin
					if (last_step) begin
						core_ready <= 1'b1;  // Product complete after this add.
						state <= CORE_IDLE;
					end else begin
						step_cnt <= step_cnt + 1'b1;
					end
				end
				default: begin
					state <= CORE_IDLE;
				end
			endcase
		end
	end

	// Accumulator datapath.
	always_ff @(posedge clk) begin
		if (state == CORE_IDLE) begin
			r_factor <= factor_a;             // Track the conditioner's output.
			r_addvalue <= PROD_W'(factor_b);  // Zero extended multiplicand.
			product <= '0;
		end else begin
			r_factor <= r_factor >> STEP_SIZE;
			r_addvalue <= r_addvalue << STEP_SIZE;
			product <= product + partial;
		end
	end

endmodule

`default_nettype wire

// ==== src/mul_result_select.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_result_select (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire                         core_ready,
	input  wire [mul_pkg::PROD_W-1:0]   product,
	input  wire                         neg_product,
	input  wire                         take_high,
	output logic                        done,
	output logic [mul_pkg::XLEN-1:0]    result
);

	import mul_pkg::*;

	logic [PROD_W-1:0] fixed_prod;  // Product with the sign restored.
	logic [XLEN-1:0]   word_sel;    // Word picked for the requester.

	// Negate the magnitude product when exactly one operand was negative.
	assign fixed_prod = neg_product ? (~product + PROD_W'(1)) : product;

	// MUL takes bits 31:0, the MULH family bits 63:32.
	assign word_sel = take_high ? fixed_prod[PROD_W-1:XLEN] : fixed_prod[XLEN-1:0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			done <= 1'b0;
			result <= '0;
		end else begin
			done <= core_ready;  // Single pulse, core_ready lasts one cycle.
			if (core_ready) begin
				result <= word_sel;  // Held until the next operation.
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/mul_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_unit (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       valid,
	input  wire [mul_pkg::OP_W-1:0]   op,
	input  wire [mul_pkg::XLEN-1:0]   rs1,
	input  wire [mul_pkg::XLEN-1:0]   rs2,
	output logic                      busy,
	output logic                      done,
	output logic [mul_pkg::XLEN-1:0]  result
);

	import mul_pkg::*;

	logic              start;        // Conditioner to core.
	logic [XLEN-1:0]   factor_a;     // Magnitude of rs1.
	logic [XLEN-1:0]   factor_b;     // Magnitude of rs2.
	logic              neg_product;  // Held for the result stage.
	logic              take_high;
	logic              core_busy;    // Core back to conditioner.
	logic              core_ready;   // Core to result stage.
	logic [PROD_W-1:0] product;

	mul_operand_conditioner cond0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.valid       (valid),
		.op          (op),
		.rs1         (rs1),
		.rs2         (rs2),
		.core_busy   (core_busy),
		.busy        (busy),
		.start       (start),
		.factor_a    (factor_a),
		.factor_b    (factor_b),
		.neg_product (neg_product),
		.take_high   (take_high)
	);

	mul_unsigned_core core0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.factor_a   (factor_a),
		.factor_b   (factor_b),
		.core_busy  (core_busy),
		.core_ready (core_ready),
		.product    (product)
	);

	mul_result_select rsel0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.core_ready  (core_ready),
		.product     (product),
		.neg_product (neg_product),
		.take_high   (take_high),
		.done        (done),
		.result      (result)
	);

endmodule

`default_nettype wire

// ==== verification/mul_unit_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_unit_properties (
	input wire clk,
	input wire rst_n,
	input wire valid,
	input wire busy,
	input wire done
);

	logic accepted;    // Request taken at this edge.
	int   fail_cnt = 0;  // Failed property attempts, watched by the testbench.

	assign accepted = valid && !busy;

	// Single-cycle done pulse.
	assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
		else begin
			$error("done stayed high for more than one cycle");
			fail_cnt++;
		end

	// Result registered on the sixth edge after acceptance, seen at the seventh sample.
	assert property (@(posedge clk) disable iff (!rst_n) accepted |=> !done [*6] ##1 done)
		else begin
			$error("done did not arrive exactly 6 cycles after an accepted request");
			fail_cnt++;
		end

	// Unit stays busy until the done cycle.
	assert property (@(posedge clk) disable iff (!rst_n) accepted |=> busy [*6])
		else begin
			$error("busy dropped between acceptance and done");
			fail_cnt++;
		end

	assert property (@(posedge clk) !rst_n |=> !busy && !done)
		else begin
			$error("busy or done high after reset");
			fail_cnt++;
		end

endmodule

bind mul_unit mul_unit_properties props0 (
	.clk   (clk),
	.rst_n (rst_n),
	.valid (valid),
	.busy  (busy),
	.done  (done)
);

`default_nettype wire

// ==== verification/mul_unit_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_unit_tb;

	import mul_pkg::*;

	localparam int CLK_PERIOD = 40;      // 25 MHz.
	localparam int RESET_CYCLES = 16;
	localparam int DONE_TIMEOUT = 20;    // Cycles allowed from acceptance to done.
	localparam int IDLE_TIMEOUT = 20;    // Cycles allowed for busy to drop.
	localparam int RANDOM_ROWS = 200;
	localparam int QUIET_CYCLES = 10;    // Window watched for a stray done.
	localparam int DRAIN_CYCLES = 2;     // Lets the last property attempts finish.

	// One stimulus row with its expected result.
	typedef struct {
		logic [OP_W-1:0] op;
		logic [XLEN-1:0] rs1;
		logic [XLEN-1:0] rs2;
		logic            intrude;  // Hold a second request while busy.
		logic [XLEN-1:0] exp;
	} row_t;

	logic            clk;
	logic            rst_n;
	logic            valid;
	logic [OP_W-1:0] op;
	logic [XLEN-1:0] rs1;
	logic [XLEN-1:0] rs2;
	logic            busy;
	logic            done;
	logic [XLEN-1:0] result;

	row_t rows[$];  // Corner cases first, random rows after.

	mul_unit dut0 (
		.clk    (clk),
		.rst_n  (rst_n),
		.valid  (valid),
		.op     (op),
		.rs1    (rs1),
		.rs2    (rs2),
		.busy   (busy),
		.done   (done),
		.result (result)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Reference model from the ISA rules, full product then word select.
	function automatic logic [XLEN-1:0] model_result(input logic [OP_W-1:0] m_op,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		logic signed [2*XLEN+1:0] ext_a;
		logic signed [2*XLEN+1:0] ext_b;
		logic signed [2*XLEN+1:0] full;
		logic                     a_signed;
		logic                     b_signed;
		a_signed = (m_op == OP_MULH) || (m_op == OP_MULHSU);  // rs1 signed for MULH, MULHSU.
		b_signed = (m_op == OP_MULH);                         // rs2 signed for MULH only.
		ext_a = a_signed ? {{(XLEN + 2){a[XLEN-1]}}, a} : {{(XLEN + 2){1'b0}}, a};
		ext_b = b_signed ? {{(XLEN + 2){b[XLEN-1]}}, b} : {{(XLEN + 2){1'b0}}, b};
		full = ext_a * ext_b;  // Exact, the product fits in 65 bits.
		return (m_op == OP_MUL) ? full[XLEN-1:0] : full[2*XLEN-1:XLEN];
	endfunction

	task automatic abort_run();
		$display("CHECKS FAILED");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic check_word(input string name, input logic [XLEN-1:0] expected,
		input logic [XLEN-1:0] actual);
		assert (actual === expected) else begin
			$display("ERROR %0t %s expected %h got %h", $time, name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		assert (actual === expected) else begin
			$display("ERROR %0t %s expected %b got %b", $time, name, expected, actual);
			abort_run();
		end
	endtask

	task automatic add_row(input logic [OP_W-1:0] r_op, input logic [XLEN-1:0] a,
		input logic [XLEN-1:0] b, input logic intrude);
		row_t r;
		r.op = r_op;
		r.rs1 = a;
		r.rs2 = b;
		r.intrude = intrude;
		r.exp = model_result(r_op, a, b);  // Expected value fixed at build time.
		rows.push_back(r);
	endtask

	task automatic build_table();
		logic [OP_W-1:0] r_op;
		// MUL low word, signs do not matter.
		add_row(OP_MUL, 32'h0000_0000, 32'h0000_0000, 1'b0);
		add_row(OP_MUL, 32'h0000_0001, 32'h0000_0001, 1'b0);
		add_row(OP_MUL, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
		add_row(OP_MUL, 32'h0000_0007, 32'hffff_fffd, 1'b0);  // 7 times -3.
		add_row(OP_MUL, 32'h1234_5678, 32'h9abc_def0, 1'b0);
		add_row(OP_MUL, 32'hffff_ffff, 32'h0000_0001, 1'b0);
		add_row(OP_MUL, 32'h8000_0000, 32'h0000_0002, 1'b0);
		// MULHU.
		add_row(OP_MULHU, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
		add_row(OP_MULHU, 32'h8000_0000, 32'h8000_0000, 1'b0);
		add_row(OP_MULHU, 32'h1234_5678, 32'h9abc_def0, 1'b0);
		add_row(OP_MULHU, 32'h0000_0001, 32'hffff_ffff, 1'b0);
		// MULH, including the most negative value.
		add_row(OP_MULH, 32'h8000_0000, 32'h8000_0000, 1'b0);
		add_row(OP_MULH, 32'h8000_0000, 32'hffff_ffff, 1'b0);
		add_row(OP_MULH, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
		add_row(OP_MULH, 32'h0000_0007, 32'hffff_fffd, 1'b0);
		add_row(OP_MULH, 32'h7fff_ffff, 32'h7fff_ffff, 1'b0);
		add_row(OP_MULH, 32'h0000_0000, 32'h8000_0000, 1'b0);
		// MULHSU, rs1 signed and rs2 unsigned.
		add_row(OP_MULHSU, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
		add_row(OP_MULHSU, 32'h8000_0000, 32'hffff_ffff, 1'b0);
		add_row(OP_MULHSU, 32'h0000_0005, 32'h8000_0000, 1'b0);
		// Second request while busy must be dropped.
		add_row(OP_MULH, 32'h8000_0000, 32'h0000_0003, 1'b1);
		add_row(OP_MUL, 32'hdead_beef, 32'h0000_1234, 1'b1);
		for (int i = 0; i < RANDOM_ROWS; i++) begin
			r_op = OP_W'($urandom_range(3, 0));
			add_row(r_op, $urandom, $urandom, (i % 25) == 7);  // A few intrusions.
		end
	endtask

	// Called on a falling edge, returns on the falling edge where busy is low.
	task automatic wait_idle();
		int cycles;
		cycles = 0;
		while (busy !== 1'b0) begin
			if (cycles >= IDLE_TIMEOUT) begin
				$display("Timeout: busy did not drop within %0d cycles.", IDLE_TIMEOUT);
				abort_run();
			end
			@(negedge clk);
			cycles++;
		end
	endtask

	// Returns on the falling edge where done is high.
	task automatic wait_done();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (done !== 1'b1) begin
			if (cycles >= DONE_TIMEOUT) begin
				$display("Timeout: no done within %0d cycles of the request.", DONE_TIMEOUT);
				abort_run();
			end
			@(negedge clk);
			cycles++;
		end
	endtask

	task automatic apply_row(input row_t r);
		wait_idle();
		op = r.op;
		rs1 = r.rs1;
		rs2 = r.rs2;
		valid = 1'b1;  // Taken on the next rising edge.
		@(negedge clk);
		valid = 1'b0;
		if (r.intrude) begin
			check_bit("busy", 1'b1, busy);
			op = OP_MULHU;
			rs1 = ~r.rs1;  // Different operands, would change the result if taken.
			rs2 = ~r.rs2;
			valid = 1'b1;  // Held over every edge of the busy window.
		end
		wait_done();
		valid = 1'b0;  // Dropped before busy falls.
		check_word("result", r.exp, result);
		if (r.intrude) begin
			// A taken intrusion would bring a second done inside this window.
			repeat (QUIET_CYCLES) begin
				@(negedge clk);
				check_bit("done", 1'b0, done);
			end
		end
	endtask

	// Bound handshake properties end the run like any other check.
	always @(negedge clk) begin
		assert (dut0.props0.fail_cnt == 0) else begin
			$display("A bound handshake property of the unit failed.");
			abort_run();
		end
	end

	initial begin
		void'($urandom(32'hf4c4d590));
		rst_n = 1'b0;
		valid = 1'b0;
		op = OP_MUL;
		rs1 = '0;
		rs2 = '0;
		build_table();
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_bit("busy", 1'b0, busy);  // Idle straight out of reset.
		check_bit("done", 1'b0, done);
		check_word("result", '0, result);
		foreach (rows[i]) begin
			apply_row(rows[i]);
		end
		repeat (DRAIN_CYCLES) @(negedge clk);
		if (dut0.props0.fail_cnt == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule

`default_nettype wire

// ==== compile.f ====
src/mul_pkg.sv
src/mul_operand_conditioner.sv
src/mul_unsigned_core.sv
src/mul_result_select.sv
src/mul_unit.sv
verification/mul_unit_properties.sv
verification/mul_unit_tb.sv
